// File: src.f
lvdc_pkg.sv
phase_timer.sv
addr_reg.sv
octal_drive_decode.sv
core_plane.sv
addr_unit_top.sv
addr_unit_assert.sv
addr_unit_tb.sv

// File: Makefile
TOP := addr_unit_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f src.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// File: addr_unit_tb.sv
`timescale 1ns/1ps

module addr_unit_tb
    import lvdc_pkg::*;
();

    localparam int num_tests       = 15;
    localparam int reset_cycles    = 3;
    localparam int watchdog_cycles = num_tests * 20 + reset_cycles;

    typedef enum logic [1:0] {act_write, act_read, act_noload, act_clear} act_t;

    logic   sim_clk;
    logic   rst_n;
    logic   addr_req;
    logic   load_strobe;
    logic   clear;
    addr_t  tr;
    logic   wr_en;
    word_t  wr_data;
    logic   ta;
    drive_t x_lo_n;
    drive_t x_hi_n;
    drive_t y_n;
    word_t  rd_data;
    logic   rd_valid;

    // stimulus table with one row per test
    string  test_name [num_tests];
    act_t   test_act  [num_tests];
    addr_t  test_addr [num_tests];
    word_t  test_word [num_tests];
    int     n_entries;
    word_t  model [plane_words];   // expected plane contents
    addr_t  held_addr;             // address the register should hold

    addr_unit_top addr_unit_top_inst (.*);

    initial begin
        sim_clk = 1'b0;
        forever #5 sim_clk = ~sim_clk;
    end

    ////////////////////////////////////////
    // reporting and compares
    ////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_drive(input string name, input drive_t exp, input drive_t act);
        if (act !== exp) abort_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) abort_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) abort_run($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
    endtask

    // bank with only the line of the given octal value pulled low
    function automatic drive_t one_low_bank(input field_t f);
        drive_t bank;
        for (int i = 0; i < drive_w; i++) begin
            bank[i] = (i != int'(f));
        end
        return bank;
    endfunction

    function automatic logic lines_idle();
        return (x_lo_n === '1) && (x_hi_n === '1) && (y_n === '1);
    endfunction

    task automatic add_entry(input string name, input act_t act, input addr_t a);
        test_name[n_entries] = name;
        test_act[n_entries]  = act;
        test_addr[n_entries] = a;
        n_entries++;
    endtask

    task automatic build_table();
        addr_t cur;
        n_entries = 0;
        add_entry("write_000", act_write, 9'o000);
        add_entry("write_123", act_write, 9'o123);
        add_entry("write_765", act_write, 9'o765);
        add_entry("write_407", act_write, 9'o407);   // sector bit set
        add_entry("write_070", act_write, 9'o070);
        add_entry("read_123", act_read, 9'o123);
        add_entry("read_765", act_read, 9'o765);
        add_entry("read_407", act_read, 9'o407);
        add_entry("read_070", act_read, 9'o070);
        add_entry("stray_load_321", act_noload, 9'o321);
        add_entry("clear", act_clear, 9'o000);
        add_entry("read_765_again", act_read, 9'o765);
        add_entry("rewrite_765", act_write, 9'o765);
        add_entry("reread_765", act_read, 9'o765);
        add_entry("read_000", act_read, 9'o000);
        cur = '0;
        for (int i = 0; i < n_entries; i++) begin
            case (test_act[i])
                act_write: begin
                    test_word[i] = word_t'($urandom);
                    model[test_addr[i]] = test_word[i];
                    cur = test_addr[i];
                end
                act_read: begin
                    test_word[i] = model[test_addr[i]];
                    cur = test_addr[i];
                end
                act_noload: test_word[i] = model[cur];   // address must not move
                default: begin
                    cur = '0;
                    test_word[i] = model[0];
                end
            endcase
        end
    endtask

    ////////////////////////////////////////
    // bus actions
    ////////////////////////////////////////

    task automatic load_address(input string name, input addr_t a);
        int n;
        addr_req = 1'b1;
        @(posedge sim_clk);
        #1;
        addr_req = 1'b0;
        check_bit({name, " ta set"}, 1'b1, ta);
        tr = a;
        load_strobe = 1'b1;
        n = 0;
        while (ta && n < phase_len) begin    // held until the latch takes it
            @(posedge sim_clk);
            #1;
            n++;
        end
        load_strobe = 1'b0;
        if (ta) abort_run($sformatf("%s: address load never accepted", name));
    endtask

    task automatic stray_load(input string name, input addr_t a);
        tr = a;
        load_strobe = 1'b1;
        repeat (phase_len) begin   // spans every bit time of a phase
            @(posedge sim_clk);
            #1;
            check_bit({name, " ta"}, 1'b0, ta);
        end
        load_strobe = 1'b0;
    endtask

    task automatic wait_decode(input string name);
        int n;
        n = 0;
        do begin
            @(posedge sim_clk);
            #1;
            n++;
        end while (lines_idle() && n <= phase_len);
        if (lines_idle()) abort_run($sformatf("%s: no decode seen within a phase", name));
    endtask

    task automatic decode_and_read(input string name, input addr_t a, input word_t w,
                                   input logic is_write);
        wait_decode(name);
        check_drive({name, " x_lo_n"}, one_low_bank(a[2:0]), x_lo_n);
        check_drive({name, " y_n"}, one_low_bank(a[5:3]), y_n);
        check_drive({name, " x_hi_n"}, one_low_bank(a[8:6]), x_hi_n);
        if (is_write) begin
            wr_en   = 1'b1;
            wr_data = w;
        end
        @(posedge sim_clk);
        #1;
        wr_en = 1'b0;
        check_bit({name, " rd_valid"}, 1'b1, rd_valid);
        if (!is_write) check_word({name, " rd_data"}, w, rd_data);
        check_drive({name, " x_lo_n idle"}, '1, x_lo_n);
        check_drive({name, " y_n idle"}, '1, y_n);
        check_drive({name, " x_hi_n idle"}, '1, x_hi_n);
    endtask

    task automatic run_entry(input int i);
        case (test_act[i])
            act_noload: stray_load(test_name[i], test_addr[i]);
            act_clear: begin
                clear = 1'b1;
                repeat (2) begin   // one of two bit times always recirculates
                    @(posedge sim_clk);
                    #1;
                end
                clear = 1'b0;
                held_addr = '0;
            end
            default: begin
                load_address(test_name[i], test_addr[i]);
                held_addr = test_addr[i];
            end
        endcase
        decode_and_read(test_name[i], held_addr, test_word[i], test_act[i] == act_write);
    endtask

    ////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////

    initial begin
        rst_n       = 1'b0;
        addr_req    = 1'b0;
        load_strobe = 1'b0;
        clear       = 1'b0;
        tr          = '0;
        wr_en       = 1'b0;
        wr_data     = '0;
        held_addr   = '0;
        void'($urandom(6));
        build_table();
        repeat (reset_cycles) @(posedge sim_clk);
        #1;
        rst_n = 1'b1;
        check_bit("reset ta", 1'b0, ta);
        check_bit("reset rd_valid", 1'b0, rd_valid);
        check_drive("reset x_lo_n", '1, x_lo_n);
        check_drive("reset y_n", '1, y_n);
        check_drive("reset x_hi_n", '1, x_hi_n);
        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
        end
        $display("test passed");
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge sim_clk);
        abort_run("watchdog expired, the run hung before all tests finished");
    end

endmodule

// File: addr_unit_assert.sv
`timescale 1ns/1ps

module addr_unit_assert
    import lvdc_pkg::*;
(
    input logic   sim_clk,
    input logic   rst_n,
    input logic   v1,
    input logic   addr_req,
    input logic   load_strobe,
    input logic   clear,
    input logic   ta,
    input drive_t x_lo_n,
    input drive_t x_hi_n,
    input drive_t y_n,
    input logic   rd_valid
);

    logic decode_on;
    logic load_acc;

    assign decode_on = (x_lo_n != '1) && (x_hi_n != '1) && (y_n != '1);
    assign load_acc  = v1 && ta && load_strobe && !clear;   // load taken by the register

    bank_one_low: assert property (@(posedge sim_clk) disable iff (!rst_n)
        ($countones(~x_lo_n) <= 1) && ($countones(~x_hi_n) <= 1) && ($countones(~y_n) <= 1))
        else $error("more than one drive line low in a bank");

    valid_after_decode: assert property (@(posedge sim_clk) disable iff (!rst_n)
        decode_on |=> rd_valid)
        else $error("rd_valid missing one cycle after a decode");

    valid_only_after_decode: assert property (@(posedge sim_clk) disable iff (!rst_n)
        rd_valid |-> $past(decode_on))
        else $error("rd_valid without a decode in the cycle before");

    ta_drops_on_load: assert property (@(posedge sim_clk) disable iff (!rst_n)
        (load_acc && !addr_req) |=> !ta)
        else $error("ta still set after an accepted load");

endmodule

bind addr_unit_top addr_unit_assert addr_unit_assert_inst (.*);

// File: addr_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module addr_unit_top
    import lvdc_pkg::*;
(
    input  logic   sim_clk,
    input  logic   rst_n,
    input  logic   addr_req,
    input  logic   load_strobe,
    input  logic   clear,
    input  addr_t  tr,
    input  logic   wr_en,
    input  word_t  wr_data,
    output logic   ta,
    output drive_t x_lo_n,
    output drive_t x_hi_n,
    output drive_t y_n,
    output word_t  rd_data,
    output logic   rd_valid
);

    logic   v1;
    logic   v4mod6;
    field_t x_lo;
    field_t y;
    field_t x_hi;

    phase_timer phase_timer_inst (
        .sim_clk (sim_clk),
        .rst_n   (rst_n),
        .v1      (v1),
        .v4mod6  (v4mod6)
    );

    addr_reg addr_reg_inst (
        .sim_clk     (sim_clk),
        .rst_n       (rst_n),
        .v1          (v1),
        .addr_req    (addr_req),
        .load_strobe (load_strobe),
        .clear       (clear),
        .tr          (tr),
        .ta          (ta),
        .x_lo        (x_lo),
        .y           (y),
        .x_hi        (x_hi)
    );

    ////////////////////////////////////////
    // drive line banks
    ////////////////////////////////////////

    octal_drive_decode x_lo_decode_inst (
        .sim_clk (sim_clk),
        .rst_n   (rst_n),
        .v4mod6  (v4mod6),
        .field   (x_lo),
        .lines   (x_lo_n)
    );

    octal_drive_decode x_hi_decode_inst (
        .sim_clk (sim_clk),
        .rst_n   (rst_n),
        .v4mod6  (v4mod6),
        .field   (x_hi),
        .lines   (x_hi_n)
    );

    octal_drive_decode y_decode_inst (
        .sim_clk (sim_clk),
        .rst_n   (rst_n),
        .v4mod6  (v4mod6),
        .field   (y),
        .lines   (y_n)
    );

    core_plane core_plane_inst (
        .sim_clk  (sim_clk),
        .rst_n    (rst_n),
        .x_lo_n   (x_lo_n),
        .x_hi_n   (x_hi_n),
        .y_n      (y_n),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

endmodule

`default_nettype wire

// File: core_plane.sv
`timescale 1ns/1ps
`default_nettype none

module core_plane
    import lvdc_pkg::*;
(
    input  logic   sim_clk,
    input  logic   rst_n,
    input  drive_t x_lo_n,
    input  drive_t x_hi_n,
    input  drive_t y_n,
    input  logic   wr_en,
    input  word_t  wr_data,
    output word_t  rd_data,
    output logic   rd_valid
);

    word_t  mem [plane_words];
    field_t xl_idx;
    field_t xh_idx;
    field_t y_idx;
    logic   xl_ok;
    logic   xh_ok;
    logic   y_ok;
    logic   sel_ok;
    addr_t  sel_addr;

    // returns {exactly one line low, index of the low line}
    function automatic logic [field_w:0] encode_bank(input drive_t bank_n);
        int     lows;
        field_t idx;
        lows = 0;
        idx  = '0;
        for (int i = 0; i < drive_w; i++) begin
            if (!bank_n[i]) begin
                lows++;
                idx = field_t'(i);
            end
        end
        return {lows == 1, idx};
    endfunction

    assign {xl_ok, xl_idx} = encode_bank(x_lo_n);
    assign {xh_ok, xh_idx} = encode_bank(x_hi_n);
    assign {y_ok, y_idx}   = encode_bank(y_n);

    assign sel_ok   = xl_ok && xh_ok && y_ok;
    assign sel_addr = {xh_idx, y_idx, xl_idx};

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    always_ff @(posedge sim_clk) begin
        if (wr_en && sel_ok) begin
            mem[sel_addr] <= wr_data;
        end
        if (sel_ok) begin
            rd_data <= wr_en ? wr_data : mem[sel_addr];   // write-through on a write cycle
        end
    end

    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= sel_ok;
        end
    end

endmodule

`default_nettype wire

// File: octal_drive_decode.sv
`timescale 1ns/1ps
`default_nettype none

module octal_drive_decode
    import lvdc_pkg::*;
(
    input  logic   sim_clk,
    input  logic   rst_n,
    input  logic   v4mod6,
    input  field_t field,
    output drive_t lines
);

    // one line pulled low for a single bit time per phase
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            lines <= '1;
        end else if (v4mod6) begin
            lines <= ~(drive_t'(1) << field);
        end else begin
            lines <= '1;    // bank idle
        end
    end

endmodule

`default_nettype wire

// File: addr_reg.sv
`timescale 1ns/1ps
`default_nettype none

module addr_reg
    import lvdc_pkg::*;
(
    input  logic   sim_clk,
    input  logic   rst_n,
    input  logic   v1,
    input  logic   addr_req,
    input  logic   load_strobe,
    input  logic   clear,
    input  addr_t  tr,
    output logic   ta,
    output field_t x_lo,
    output field_t y,
    output field_t x_hi
);

    addr_t addr_q;
    logic  clr_ok;
    logic  load_ok;

    // nothing moves in the register outside a bit time
    assign clr_ok  = v1 && clear;
    assign load_ok = v1 && ta && load_strobe && !clear;    // clear wins over load

    ////////////////////////////////////////
    // transfer-address latch
    ////////////////////////////////////////

    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            ta <= 1'b0;
        end else if (addr_req) begin
            ta <= 1'b1;
        end else if (load_ok) begin
            ta <= 1'b0;     // one address per request
        end
    end

    ////////////////////////////////////////
    // address bits
    ////////////////////////////////////////

    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (clr_ok) begin
            addr_q <= '0;
        end else if (load_ok) begin
            addr_q <= tr;
        end
        // otherwise the bits recirculate unchanged
    end

    // octal split, sector bit lands in x_hi[2]
    assign x_lo = addr_q[field_w-1:0];
    assign y    = addr_q[2*field_w-1:field_w];
    assign x_hi = addr_q[addr_w-1:2*field_w];

endmodule

`default_nettype wire

// File: phase_timer.sv
`timescale 1ns/1ps
`default_nettype none

module phase_timer
    import lvdc_pkg::*;
(
    input  logic sim_clk,
    input  logic rst_n,
    output logic v1,
    output logic v4mod6
);

    logic [phase_cnt_w-1:0] cnt;
    logic                   wrap;
    logic                   last_next;

    assign wrap      = (cnt == phase_cnt_w'(phase_last));
    assign last_next = (cnt == phase_cnt_w'(phase_last - 1));   // next bit time ends the phase

    ////////////////////////////////////////
    // bit-time counter
    ////////////////////////////////////////

    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (wrap) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    ////////////////////////////////////////
    // strobes
    ////////////////////////////////////////

    // registered one bit time early so they line up with cnt
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            v1     <= 1'b0;
            v4mod6 <= 1'b0;
        end else begin
            v1     <= !last_next;   // recirculate on every bit time but the last
            v4mod6 <= last_next;    // decode on the last
        end
    end

endmodule

`default_nettype wire

// File: lvdc_pkg.sv
package lvdc_pkg;

    ////////////////////////////////////////
    // address path widths
    ////////////////////////////////////////

    localparam int addr_w  = 9;     // sector bit folded in as the top bit
    localparam int field_w = 3;     // one octal digit
    localparam int drive_w = 8;     // one drive line per octal value
    localparam int word_w  = 26;

    // one word per x-low / x-high / y crossing
    localparam int plane_words = 1 << addr_w;

    ////////////////////////////////////////
    // phase timing
    ////////////////////////////////////////

    localparam int phase_len   = 6;                 // bit times per memory phase
    localparam int phase_last  = phase_len - 1;     // bit time of the decode strobe
    localparam int phase_cnt_w = $clog2(phase_len);

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////

    typedef logic [addr_w-1:0]  addr_t;
    typedef logic [field_w-1:0] field_t;
    typedef logic [drive_w-1:0] drive_t;   // active low, one line per octal value
    typedef logic [word_w-1:0]  word_t;

endpackage
